// File: logic/lsu_pkg.sv
package lsu_pkg;

    // Address and data widths
    localparam int ADDR_WIDTH      = 32;
    localparam int DATA_WIDTH      = 32;

    // 32-byte lines of 8 words, 16 lines direct mapped
    localparam int OFFSET_WIDTH    = 5;
    localparam int INDEX_WIDTH     = 4;
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int TAG_WIDTH       = LINE_ADDR_WIDTH - INDEX_WIDTH;
    localparam int WORD_SEL_WIDTH  = OFFSET_WIDTH - 2;
    localparam int WORDS_PER_LINE  = 1 << WORD_SEL_WIDTH;
    localparam int NUM_LINES       = 1 << INDEX_WIDTH;

    // Miss handling queue and op identifiers
    localparam int MHQ_DEPTH       = 4;
    localparam int OP_TAG_WIDTH    = 5;

    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_func_e;

    typedef enum logic [1:0] {
        ST_HIT       = 2'b00,
        ST_MISS_NEW  = 2'b01,
        ST_MISS_PEND = 2'b10,
        ST_REPLAY    = 2'b11
    } lsu_status_e;

    // Address field helpers
    function automatic logic [LINE_ADDR_WIDTH-1:0] addr_line(input logic [ADDR_WIDTH-1:0] addr);
        return addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    endfunction

    function automatic logic [WORD_SEL_WIDTH-1:0] addr_word(input logic [ADDR_WIDTH-1:0] addr);
        return addr[OFFSET_WIDTH-1:2];
    endfunction

    function automatic logic [INDEX_WIDTH-1:0] line_index(input logic [LINE_ADDR_WIDTH-1:0] line);
        return line[INDEX_WIDTH-1:0];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] line_tag(input logic [LINE_ADDR_WIDTH-1:0] line);
        return line[LINE_ADDR_WIDTH-1:INDEX_WIDTH];
    endfunction

endpackage

// File: logic/lsu_d1_if.sv
`timescale 1ns/1ps

// D1 stage contents read by the array, the MHQ and D2
interface lsu_d1_if;

    logic                              valid;
    logic                              lookup_valid;
    logic                              fill_replay;
    lsu_pkg::lsu_func_e                func;
    logic [lsu_pkg::OP_TAG_WIDTH-1:0]  op_tag;
    logic [lsu_pkg::ADDR_WIDTH-1:0]    addr;
    logic [lsu_pkg::DATA_WIDTH-1:0]    wdata;
    logic                              retire;

    modport d1 (
        output valid, lookup_valid, fill_replay, func, op_tag, addr, wdata, retire
    );

    modport array (
        input lookup_valid, func, addr, wdata, retire
    );

    modport mhq (
        input lookup_valid, addr
    );

    modport d2 (
        input valid, fill_replay, func, op_tag
    );

endinterface

// File: logic/lsu_d1.sv
`timescale 1ns/1ps

module lsu_d1 (
    input  logic                                clk,
    input  logic                                n_rst,

    input  logic                                i_flush,

    // Fill port, checked for a same-cycle line conflict
    input  logic                                i_fill_en,
    input  logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] i_fill_addr,

    // Op entering from the D0 side
    input  logic                                i_valid,
    input  lsu_pkg::lsu_func_e                  i_func,
    input  logic [lsu_pkg::OP_TAG_WIDTH-1:0]    i_op_tag,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]      i_addr,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_wdata,
    input  logic                                i_retire,

    lsu_d1_if.d1                                d1
);

    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] op_line;
    logic                                fill_conflict;
    logic                                op_live;

    assign op_line = lsu_pkg::addr_line(i_addr);

    // A fill to the op's own line in this cycle would race the lookup,
    // so the op skips the array and MHQ and replays instead
    assign fill_conflict = i_fill_en & (i_fill_addr == op_line);

    assign op_live = i_valid & ~i_flush;

    // Op payload
    always_ff @(posedge clk) begin
        d1.fill_replay <= fill_conflict;
        d1.func        <= i_func;
        d1.op_tag      <= i_op_tag;
        d1.addr        <= i_addr;
        d1.wdata       <= i_wdata;
        d1.retire      <= i_retire;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            d1.valid <= 1'b0;
        end else begin
            d1.valid <= op_live;
        end
    end

    // Lookup only for ops that are live and free of a fill conflict
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            d1.lookup_valid <= 1'b0;
        end else begin
            d1.lookup_valid <= op_live & ~fill_conflict;
        end
    end

endmodule

// File: logic/lsu_dc_array.sv
`timescale 1ns/1ps

module lsu_dc_array (
    input  logic                                clk,
    input  logic                                n_rst,

    lsu_d1_if.array                             array,

    // Line install from memory
    input  logic                                i_fill_en,
    input  logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] i_fill_addr,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_fill_data,

    // Lookup result for D2 and the MHQ
    output logic                                o_hit,
    output logic [lsu_pkg::DATA_WIDTH-1:0]      o_rdata
);

    logic [lsu_pkg::NUM_LINES-1:0]      valid_q;
    logic [lsu_pkg::TAG_WIDTH-1:0]      tag_q  [lsu_pkg::NUM_LINES];
    logic [lsu_pkg::DATA_WIDTH-1:0]     data_q [lsu_pkg::NUM_LINES][lsu_pkg::WORDS_PER_LINE];

    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] op_line;
    logic [lsu_pkg::INDEX_WIDTH-1:0]     op_index;
    logic [lsu_pkg::TAG_WIDTH-1:0]       op_tag;
    logic [lsu_pkg::WORD_SEL_WIDTH-1:0]  op_word;
    logic [lsu_pkg::INDEX_WIDTH-1:0]     fill_index;
    logic [lsu_pkg::TAG_WIDTH-1:0]       fill_tag;
    logic                                store_wr;

    assign op_line    = lsu_pkg::addr_line(array.addr);
    assign op_index   = lsu_pkg::line_index(op_line);
    assign op_tag     = lsu_pkg::line_tag(op_line);
    assign op_word    = lsu_pkg::addr_word(array.addr);
    assign fill_index = lsu_pkg::line_index(i_fill_addr);
    assign fill_tag   = lsu_pkg::line_tag(i_fill_addr);

    // Combinational lookup on the op held in D1
    assign o_hit   = array.lookup_valid & valid_q[op_index] & (tag_q[op_index] == op_tag);
    assign o_rdata = data_q[op_index][op_word];

    // Only retired stores that hit update the line
    assign store_wr = o_hit & (array.func == lsu_pkg::LSU_STORE) & array.retire;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
        end else if (i_fill_en) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // Fill is written last so it takes the line if both land on it
    always_ff @(posedge clk) begin
        if (store_wr) begin
            data_q[op_index][op_word] <= array.wdata;
        end
        if (i_fill_en) begin
            tag_q[fill_index] <= fill_tag;
            for (int w = 0; w < lsu_pkg::WORDS_PER_LINE; w++) begin
                data_q[fill_index][w] <= i_fill_data;
            end
        end
    end

endmodule

// File: logic/lsu_mhq.sv
`timescale 1ns/1ps

module lsu_mhq (
    input  logic                                clk,
    input  logic                                n_rst,

    lsu_d1_if.mhq                               mhq,

    // Array result for the same op
    input  logic                                i_hit,

    // Fill frees the entry holding its line
    input  logic                                i_fill_en,
    input  logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] i_fill_addr,

    // Lookup outcome for D2
    output logic                                o_match,
    output logic                                o_alloc,
    output logic                                o_full,

    // Line request to memory
    output logic                                o_mem_req_valid,
    output logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] o_mem_req_addr
);

    logic [lsu_pkg::MHQ_DEPTH-1:0]       valid_q;
    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] line_q [lsu_pkg::MHQ_DEPTH];

    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] op_line;
    logic [lsu_pkg::MHQ_DEPTH-1:0]       match_vec;
    logic [lsu_pkg::MHQ_DEPTH-1:0]       fill_clr;
    logic [lsu_pkg::MHQ_DEPTH-1:0]       free_vec;
    logic [lsu_pkg::MHQ_DEPTH-1:0]       alloc_sel;
    logic                                fill_same_line;

    assign op_line = lsu_pkg::addr_line(mhq.addr);

    // CAM against the D1 op and against the incoming fill
    always_comb begin
        for (int i = 0; i < lsu_pkg::MHQ_DEPTH; i++) begin
            match_vec[i] = valid_q[i] & (line_q[i] == op_line);
            fill_clr[i]  = i_fill_en & valid_q[i] & (line_q[i] == i_fill_addr);
        end
    end

    // Lowest free entry as a one-hot select
    assign free_vec  = ~valid_q;
    assign alloc_sel = free_vec & (~free_vec + 1'b1);

    // An entry allocated for a line that is being installed now would never be freed
    assign fill_same_line = i_fill_en & (i_fill_addr == op_line);

    assign o_full  = &valid_q;
    assign o_match = mhq.lookup_valid & (|match_vec);
    assign o_alloc = mhq.lookup_valid & ~i_hit & ~(|match_vec) & ~o_full & ~fill_same_line;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~fill_clr) | (o_alloc ? alloc_sel : '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lsu_pkg::MHQ_DEPTH; i++) begin
            if (o_alloc && alloc_sel[i]) begin
                line_q[i] <= op_line;
            end
        end
    end

    // Request leaves on the same edge that registers the D2 response
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_mem_req_valid <= 1'b0;
        end else begin
            o_mem_req_valid <= o_alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (o_alloc) begin
            o_mem_req_addr <= op_line;
        end
    end

endmodule

// File: logic/lsu_d2.sv
`timescale 1ns/1ps

module lsu_d2 (
    input  logic                             clk,
    input  logic                             n_rst,

    lsu_d1_if.d2                             d2,

    // Array result
    input  logic                             i_hit,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]   i_rdata,

    // MHQ result
    input  logic                             i_match,
    input  logic                             i_alloc,
    input  logic                             i_full,

    // Response
    output logic                             o_resp_valid,
    output logic [lsu_pkg::OP_TAG_WIDTH-1:0] o_resp_tag,
    output lsu_pkg::lsu_status_e             o_resp_status,
    output logic [lsu_pkg::DATA_WIDTH-1:0]   o_resp_data
);

    lsu_pkg::lsu_status_e             status;
    logic [lsu_pkg::DATA_WIDTH-1:0]   resp_data;

    always_comb begin
        if (d2.fill_replay) begin
            status = lsu_pkg::ST_REPLAY;
        end else if (i_hit) begin
            status = lsu_pkg::ST_HIT;
        end else if (i_match) begin
            status = lsu_pkg::ST_MISS_PEND;
        end else if (i_full) begin
            // No room for a new line miss
            status = lsu_pkg::ST_REPLAY;
        end else if (i_alloc) begin
            status = lsu_pkg::ST_MISS_NEW;
        end else begin
            status = lsu_pkg::ST_REPLAY;
        end
    end

    // Only load hits carry data
    assign resp_data = ((status == lsu_pkg::ST_HIT) && (d2.func == lsu_pkg::LSU_LOAD)) ?
                       i_rdata : '0;

    always_ff @(posedge clk) begin
        o_resp_tag    <= d2.op_tag;
        o_resp_status <= status;
        o_resp_data   <= resp_data;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= d2.valid;
        end
    end

endmodule

// File: logic/lsu_dcache_top.sv
`timescale 1ns/1ps

module lsu_dcache_top (
    input  logic                                clk,
    input  logic                                n_rst,

    input  logic                                i_flush,

    // Op entering D1
    input  logic                                i_valid,
    input  lsu_pkg::lsu_func_e                  i_func,
    input  logic [lsu_pkg::OP_TAG_WIDTH-1:0]    i_op_tag,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]      i_addr,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_wdata,
    input  logic                                i_retire,

    // Fill from memory
    input  logic                                i_fill_en,
    input  logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] i_fill_addr,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_fill_data,

    // Response from D2
    output logic                                o_resp_valid,
    output logic [lsu_pkg::OP_TAG_WIDTH-1:0]    o_resp_tag,
    output lsu_pkg::lsu_status_e                o_resp_status,
    output logic [lsu_pkg::DATA_WIDTH-1:0]      o_resp_data,

    // Line request to memory
    output logic                                o_mem_req_valid,
    output logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] o_mem_req_addr
);

    logic                           hit;
    logic [lsu_pkg::DATA_WIDTH-1:0] rdata;
    logic                           match;
    logic                           alloc;
    logic                           full;

    lsu_d1_if d1_bus ();

    lsu_d1 d1_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_flush     (i_flush),
        .i_fill_en   (i_fill_en),
        .i_fill_addr (i_fill_addr),
        .i_valid     (i_valid),
        .i_func      (i_func),
        .i_op_tag    (i_op_tag),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_retire    (i_retire),
        .d1          (d1_bus.d1)
    );

    lsu_dc_array dc_array_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .array       (d1_bus.array),
        .i_fill_en   (i_fill_en),
        .i_fill_addr (i_fill_addr),
        .i_fill_data (i_fill_data),
        .o_hit       (hit),
        .o_rdata     (rdata)
    );

    lsu_mhq mhq_i (
        .clk             (clk),
        .n_rst           (n_rst),
        .mhq             (d1_bus.mhq),
        .i_hit           (hit),
        .i_fill_en       (i_fill_en),
        .i_fill_addr     (i_fill_addr),
        .o_match         (match),
        .o_alloc         (alloc),
        .o_full          (full),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_req_addr  (o_mem_req_addr)
    );

    lsu_d2 d2_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .d2            (d1_bus.d2),
        .i_hit         (hit),
        .i_rdata       (rdata),
        .i_match       (match),
        .i_alloc       (alloc),
        .i_full        (full),
        .o_resp_valid  (o_resp_valid),
        .o_resp_tag    (o_resp_tag),
        .o_resp_status (o_resp_status),
        .o_resp_data   (o_resp_data)
    );

endmodule

// File: verif/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
    input  logic                                clk,
    input  logic                                n_rst,

    // Expected result of the op entering D1 on this edge
    input  logic                                i_exp_valid,
    input  logic [lsu_pkg::OP_TAG_WIDTH-1:0]    i_exp_tag,
    input  logic [1:0]                          i_exp_status,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_exp_data,
    input  logic                                i_exp_req,
    input  logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] i_exp_line,

    // DUT outputs
    input  logic                                i_resp_valid,
    input  logic [lsu_pkg::OP_TAG_WIDTH-1:0]    i_resp_tag,
    input  lsu_pkg::lsu_status_e                i_resp_status,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_resp_data,
    input  logic                                i_mem_req_valid,
    input  logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] i_mem_req_addr,

    output int                                  o_tests,
    output int                                  o_reqs,
    output int                                  o_errors,
    output int                                  o_pending
);

    typedef struct {
        int                               due;
        logic [lsu_pkg::OP_TAG_WIDTH-1:0] tag;
        logic [1:0]                       status;
        logic [lsu_pkg::DATA_WIDTH-1:0]   data;
    } resp_exp_t;

    resp_exp_t                           resp_q[$];
    int                                  req_due_q[$];
    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] req_line_q[$];
    resp_exp_t                           entry;
    resp_exp_t                           staged;
    logic                                staged_valid;
    logic                                staged_req;
    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] staged_line;
    int                                  cyc;

    function automatic bit value_ok(input string name, input logic [31:0] exp,
                                    input logic [31:0] got);
        if (got !== exp) begin
            $display("FAIL %s exp %h got %h", name, exp, got);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // Capture what the driver presented with the op on this edge
    always @(posedge clk) begin
        cyc           <= n_rst ? cyc + 1 : 0;
        staged_valid  <= n_rst & i_exp_valid;
        staged_req    <= i_exp_req;
        staged_line   <= i_exp_line;
        staged.tag    <= i_exp_tag;
        staged.status <= i_exp_status;
        staged.data   <= i_exp_data;
    end

    task automatic check_resp();
        bit ok;
        if (resp_q.size() > 0 && resp_q[0].due == cyc) begin
            entry = resp_q.pop_front();
            o_tests++;
            if (i_resp_valid !== 1'b1) begin
                $display("Test %0d: no response for tag %h on its cycle", o_tests, entry.tag);
                o_errors++;
            end else begin
                ok = value_ok("o_resp_tag", 32'(entry.tag), 32'(i_resp_tag))
                   & value_ok("o_resp_status", 32'(entry.status), 32'(i_resp_status))
                   & value_ok("o_resp_data", entry.data, i_resp_data);
                if (ok) begin
                    $display("Test %0d: tag %h status %h data %h ok",
                             o_tests, entry.tag, entry.status, entry.data);
                end else begin
                    $display("Test %0d: tag %h mismatch", o_tests, entry.tag);
                    o_errors++;
                end
            end
        end else if (i_resp_valid !== 1'b0) begin
            $display("Response with tag %h came when no op was due", i_resp_tag);
            o_errors++;
        end
    endtask

    task automatic check_req();
        logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] line;
        if (req_due_q.size() > 0 && req_due_q[0] == cyc) begin
            void'(req_due_q.pop_front());
            line = req_line_q.pop_front();
            o_reqs++;
            if (i_mem_req_valid !== 1'b1) begin
                $display("No memory request for line %h after its miss", line);
                o_errors++;
            end else if (!value_ok("o_mem_req_addr", 32'(line), 32'(i_mem_req_addr))) begin
                o_errors++;
            end
        end else if (i_mem_req_valid !== 1'b0) begin
            $display("Memory request for line %h that no miss asked for", i_mem_req_addr);
            o_errors++;
        end
    endtask

    // Outputs are registered, so they are stable here
    always @(negedge clk) begin
        if (!n_rst) begin
            o_tests  = 0;
            o_reqs   = 0;
            o_errors = 0;
        end else begin
            check_resp();
            check_req();
            // Response and request both register on the edge after D1
            if (staged_valid) begin
                entry        = staged;
                entry.due    = cyc + 1;
                resp_q.push_back(entry);
                if (staged_req) begin
                    req_due_q.push_back(cyc + 1);
                    req_line_q.push_back(staged_line);
                end
            end
        end
        o_pending = resp_q.size() + req_line_q.size();
    end

endmodule

// File: verif/lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties (
    input  logic                                                  clk,
    input  logic                                                  n_rst,
    input  logic                                                  i_op_valid,
    input  logic                                                  i_lookup_valid,
    input  logic [lsu_pkg::MHQ_DEPTH-1:0]                         i_mhq_valid,
    input  logic [lsu_pkg::MHQ_DEPTH*lsu_pkg::LINE_ADDR_WIDTH-1:0] i_mhq_lines,
    input  logic                                                  i_mem_req
);

    localparam int LW = lsu_pkg::LINE_ADDR_WIDTH;

    int fail_count = 0;

    function automatic logic dup_line(input logic [lsu_pkg::MHQ_DEPTH-1:0] vld,
                                      input logic [lsu_pkg::MHQ_DEPTH*LW-1:0] lines);
        for (int i = 0; i < lsu_pkg::MHQ_DEPTH; i++) begin
            for (int j = i + 1; j < lsu_pkg::MHQ_DEPTH; j++) begin
                if (vld[i] && vld[j] && (lines[i*LW +: LW] == lines[j*LW +: LW])) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    lookup_needs_valid: assert property (@(posedge clk) disable iff (!n_rst)
        i_lookup_valid |-> i_op_valid)
    else begin
        $error("D1 lookup_valid is high while valid is low");
        fail_count++;
    end

    unique_lines: assert property (@(posedge clk) disable iff (!n_rst)
        !dup_line(i_mhq_valid, i_mhq_lines))
    else begin
        $error("Two MHQ entries hold the same line");
        fail_count++;
    end

    // A full MHQ cannot allocate, so the next registered request stays low
    no_req_when_full: assert property (@(posedge clk) disable iff (!n_rst)
        (&i_mhq_valid) |=> !i_mem_req)
    else begin
        $error("Memory request issued while the MHQ was full");
        fail_count++;
    end

endmodule

bind lsu_d1 lsu_properties d1_props_i (
    .clk            (clk),
    .n_rst          (n_rst),
    .i_op_valid     (d1.valid),
    .i_lookup_valid (d1.lookup_valid),
    .i_mhq_valid    ('0),
    .i_mhq_lines    ('0),
    .i_mem_req      (1'b0)
);

bind lsu_mhq lsu_properties mhq_props_i (
    .clk            (clk),
    .n_rst          (n_rst),
    .i_op_valid     (1'b0),
    .i_lookup_valid (1'b0),
    .i_mhq_valid    (valid_q),
    .i_mhq_lines    ({line_q[3], line_q[2], line_q[1], line_q[0]}),
    .i_mem_req      (o_mem_req_valid)
);

// File: verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    localparam int ROW_WORDS = 8;
    localparam int MAX_ROWS  = 64;

    logic                                clk;
    logic                                n_rst;
    logic                                i_flush;
    logic                                i_valid;
    lsu_pkg::lsu_func_e                  i_func;
    logic [lsu_pkg::OP_TAG_WIDTH-1:0]    i_op_tag;
    logic [lsu_pkg::ADDR_WIDTH-1:0]      i_addr;
    logic [lsu_pkg::DATA_WIDTH-1:0]      i_wdata;
    logic                                i_retire;
    logic                                i_fill_en;
    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] i_fill_addr;
    logic [lsu_pkg::DATA_WIDTH-1:0]      i_fill_data;
    logic                                o_resp_valid;
    logic [lsu_pkg::OP_TAG_WIDTH-1:0]    o_resp_tag;
    lsu_pkg::lsu_status_e                o_resp_status;
    logic [lsu_pkg::DATA_WIDTH-1:0]      o_resp_data;
    logic                                o_mem_req_valid;
    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] o_mem_req_addr;

    // Expected results handed to the checker with each op
    logic                                exp_valid;
    logic [lsu_pkg::OP_TAG_WIDTH-1:0]    exp_tag;
    logic [1:0]                          exp_status;
    logic [lsu_pkg::DATA_WIDTH-1:0]      exp_data;
    logic                                exp_req;
    logic [lsu_pkg::LINE_ADDR_WIDTH-1:0] exp_line;

    logic [31:0] pat_mem [ROW_WORDS*MAX_ROWS];
    int          row;
    int          last_row;
    int          last_cyc;
    int          run_cyc;
    int          tests;
    int          reqs;
    int          chk_errors;
    int          pending;
    int          assert_errors;

    lsu_dcache_top dut_i (.*);

    lsu_checker checker_i (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_exp_valid     (exp_valid),
        .i_exp_tag       (exp_tag),
        .i_exp_status    (exp_status),
        .i_exp_data      (exp_data),
        .i_exp_req       (exp_req),
        .i_exp_line      (exp_line),
        .i_resp_valid    (o_resp_valid),
        .i_resp_tag      (o_resp_tag),
        .i_resp_status   (o_resp_status),
        .i_resp_data     (o_resp_data),
        .i_mem_req_valid (o_mem_req_valid),
        .i_mem_req_addr  (o_mem_req_addr),
        .o_tests         (tests),
        .o_reqs          (reqs),
        .o_errors        (chk_errors),
        .o_pending       (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] row_field(input int r, input int f);
        return pat_mem[r * ROW_WORDS + f];
    endfunction

    task automatic drive_idle();
        i_valid   = 1'b0;
        i_flush   = 1'b0;
        i_fill_en = 1'b0;
        exp_valid = 1'b0;
        exp_req   = 1'b0;
    endtask

    task automatic init_inputs();
        drive_idle();
        i_func      = lsu_pkg::LSU_LOAD;
        i_op_tag    = '0;
        i_addr      = '0;
        i_wdata     = '0;
        i_retire    = 1'b0;
        i_fill_addr = '0;
        i_fill_data = '0;
        exp_tag     = '0;
        exp_status  = '0;
        exp_data    = '0;
        exp_line    = '0;
    endtask

    // Kind 1 is a fill, kind 0 an op, kind 2 an op entering with a flush
    task automatic apply_row(input int r);
        logic [31:0] kind;
        logic [31:0] ctl;
        logic [31:0] tag;
        logic [31:0] addr;
        logic [31:0] status;
        kind   = row_field(r, 1);
        ctl    = row_field(r, 2);
        tag    = row_field(r, 3);
        addr   = row_field(r, 4);
        status = row_field(r, 6);
        if (kind == 32'h1) begin
            i_fill_en   = 1'b1;
            i_fill_addr = addr[lsu_pkg::LINE_ADDR_WIDTH-1:0];
            i_fill_data = row_field(r, 5);
        end else begin
            i_valid    = 1'b1;
            i_flush    = (kind == 32'h2);
            i_func     = lsu_pkg::lsu_func_e'(ctl[0]);
            i_retire   = ctl[1];
            i_op_tag   = tag[lsu_pkg::OP_TAG_WIDTH-1:0];
            i_addr     = addr;
            i_wdata    = row_field(r, 5);
            exp_valid  = (status != 32'hf);
            exp_tag    = tag[lsu_pkg::OP_TAG_WIDTH-1:0];
            exp_status = status[1:0];
            exp_data   = row_field(r, 7);
            // A new miss requests its line address, which drops the offset bits
            exp_req    = (status == 32'h1);
            exp_line   = addr[lsu_pkg::ADDR_WIDTH-1:lsu_pkg::OFFSET_WIDTH];
        end
    endtask

    initial begin
        n_rst = 1'b0;
        init_inputs();
        $readmemh("verif/lsu_patterns.txt", pat_mem);
        last_row = 0;
        while (last_row < MAX_ROWS && row_field(last_row, 1) !== 32'hf) begin
            last_row++;
        end
        if (last_row == MAX_ROWS || $isunknown(row_field(last_row, 0))) begin
            $display("Pattern file is missing or has no end row");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            last_cyc = int'(row_field(last_row, 0));
            repeat (8) @(negedge clk);
            n_rst = 1'b1;
            row   = 0;
            for (int cyc = 0; cyc <= last_cyc; cyc++) begin
                @(negedge clk);
                drive_idle();
                while (row < last_row && row_field(row, 0) == cyc) begin
                    apply_row(row);
                    row++;
                end
            end
            repeat (2) @(posedge clk);
            while (pending != 0) begin
                @(posedge clk);
            end
            // A few idle cycles catch stray responses or requests
            repeat (3) @(posedge clk);
            assert_errors = dut_i.d1_i.d1_props_i.fail_count
                          + dut_i.mhq_i.mhq_props_i.fail_count;
            $display(
                "Done: %0d tests, %0d memory requests, %0d check errors, %0d assertion failures",
                tests, reqs, chk_errors, assert_errors);
            if (chk_errors == 0 && assert_errors == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    // Cycle limit from the last pattern cycle
    initial begin
        run_cyc = 0;
        wait (n_rst === 1'b1);
        while (run_cyc <= last_cyc + 50) begin
            @(posedge clk);
            run_cyc++;
        end
        $display("Timeout: run went past %0d cycles after reset", last_cyc + 50);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verif/lsu_patterns.txt
// cycle kind ctl tag addr data exp_status exp_data (all hex, cycle counted after reset)
// kind 0 op, 1 fill (addr is a line address), 2 op with flush, f end; ctl bit0 store, bit1 retire
// exp_status 0 hit, 1 miss new, 2 miss pending, 3 replay, f no response

// Miss, fill, then hit on another word of the line
00 0 0 01 00001000 00000000 1 00000000
04 1 0 00 00000080 a5a50001 f 00000000
06 0 0 02 0000101c 00000000 0 a5a50001

// Retired store, store without retire, then loads of both words
08 0 3 03 00001008 12345678 0 00000000
09 0 1 04 0000100c deadbeef 0 00000000
0a 0 0 05 00001008 00000000 0 12345678
0b 0 0 06 0000100c 00000000 0 a5a50001

// Pending miss, four new misses fill the MHQ, fifth replays, then fills drain it
0e 0 0 07 00002000 00000000 1 00000000
0f 0 0 08 00002004 00000000 2 00000000
10 0 0 09 00003020 00000000 1 00000000
11 0 0 0a 00004040 00000000 1 00000000
12 0 0 0b 00005060 00000000 1 00000000
13 0 0 0c 00006080 00000000 3 00000000
16 1 0 00 00000100 11111111 f 00000000
17 1 0 00 00000181 22222222 f 00000000
18 1 0 00 00000202 33333333 f 00000000
19 1 0 00 00000283 44444444 f 00000000

// Store meets a fill to its line, replays without writing, then is issued again
1c 1 0 00 00000385 77770000 f 00000000
1c 0 3 0d 000070a4 cafef00d 3 00000000
1e 0 0 0e 000070a4 00000000 0 77770000
1f 0 3 0f 000070a4 cafef00d 0 00000000
20 0 0 10 000070a4 00000000 0 cafef00d

// Flushed op to a cold line between two hits
23 0 0 11 00003024 00000000 0 22222222
24 2 0 12 00008000 00000000 f 00000000
25 0 0 13 00004044 00000000 0 33333333

// End of patterns
28 f 0 00 00000000 00000000 f 00000000

// File: verilog.f
logic/lsu_pkg.sv
logic/lsu_d1_if.sv
logic/lsu_d1.sv
logic/lsu_dc_array.sv
logic/lsu_mhq.sv
logic/lsu_d2.sv
logic/lsu_dcache_top.sv
verif/lsu_checker.sv
verif/lsu_properties.sv
verif/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu_dcache

sources:
  - files:
      - logic/lsu_pkg.sv
      - logic/lsu_d1_if.sv
      - logic/lsu_d1.sv
      - logic/lsu_dc_array.sv
      - logic/lsu_mhq.sv
      - logic/lsu_d2.sv
      - logic/lsu_dcache_top.sv
  - target: test
    files:
      - verif/lsu_checker.sv
      - verif/lsu_properties.sv
      - verif/lsu_tb.sv
